//--- all.f
+incdir+dv
hdl/riscv_core_pkg.sv
hdl/riscv_mem_pkg.sv
hdl/riscv_em_if.sv
hdl/riscv_execute.sv
hdl/riscv_ppreg_em.sv
hdl/riscv_memstage.sv
hdl/riscv_em_top.sv
dv/tb_riscv_em_top.sv

//--- Makefile
SIM := obj_dir/Vtb_riscv_em_top

.PHONY: all run clean

all: run

$(SIM): all.f $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	verilator --binary --timing --assert -f all.f \
		--top-module tb_riscv_em_top -o Vtb_riscv_em_top

run: $(SIM)
	./$(SIM) > sim.log
	cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_riscv_em_model.svh
// ==============================
// Reference model
// ==============================

// Shadow of the data RAM, one doubleword per index
logic [63:0] shadow_mem [64];

typedef struct {
    logic        valid;
    logic        is_load;
    logic        is_store;
    logic        mis;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [63:0] value;
    logic [63:0] sdata;
} slot_t;

typedef struct {
    logic        regw;
    logic [4:0]  rd;
    logic [63:0] data;
    logic        lmis;
    logic        smis;
} wb_t;

// Record held in the pipeline register, and writebacks still to be seen
slot_t mem_slot;
wb_t   exp_q [$];

function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic sub,
                                          input logic [63:0] a, input logic [63:0] b);
    case (f3)
        3'b000:  alu_model = sub ? a - b : a + b;
        3'b001:  alu_model = a << b[5:0];
        3'b010:  alu_model = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'b100:  alu_model = a ^ b;
        3'b101:  alu_model = a >> b[5:0];
        3'b110:  alu_model = a | b;
        default: alu_model = a & b;
    endcase
endfunction

function automatic logic [63:0] load_model(input logic [63:0] addr, input logic [2:0] f3);
    logic [63:0] w;
    w = shadow_mem[addr[8:3]] >> {addr[2:0], 3'b000};
    case (f3)
        3'b000:  load_model = {{56{w[7]}}, w[7:0]};
        3'b001:  load_model = {{48{w[15]}}, w[15:0]};
        3'b010:  load_model = {{32{w[31]}}, w[31:0]};
        3'b100:  load_model = {56'd0, w[7:0]};
        3'b101:  load_model = {48'd0, w[15:0]};
        3'b110:  load_model = {32'd0, w[31:0]};
        default: load_model = w;
    endcase
endfunction

task automatic store_model(input logic [63:0] addr, input logic [2:0] f3,
                           input logic [63:0] data);
    int nbytes;
    int lane;
    nbytes = 1 << f3[1:0];
    for (int i = 0; i < nbytes; i++)
    begin
        lane = int'(addr[2:0]) + i;
        shadow_mem[addr[8:3]][8*lane +: 8] = data[8*i +: 8];
    end
endtask

// Sorts the instruction on the inputs into a pipeline record
function automatic slot_t execute_model();
    slot_t       s;
    logic [63:0] addr;
    logic [63:0] align_mask;
    s.valid      = valid;
    s.is_load    = (opcode == OPC_LOAD);
    s.is_store   = (opcode == OPC_STORE);
    s.f3         = funct3;
    s.rd         = rdaddr;
    s.sdata      = rs2data;
    addr         = rs1data + imm;
    align_mask   = (64'd1 << funct3[1:0]) - 64'd1;
    s.mis        = (s.is_load || s.is_store) && ((addr & align_mask) != 64'd0);
    if (opcode == OPC_OP)
        s.value = alu_model(funct3, funct7b5, rs1data, rs2data);
    else if (opcode == OPC_OP_IMM)
        s.value = alu_model(funct3, 1'b0, rs1data, imm);
    else
        s.value = addr;
    return s;
endfunction

// On each rising edge the memory stage completes its record before the register updates
task automatic model_edge();
    wb_t w;
    if (!stall && mem_slot.valid)
    begin
        w.rd   = mem_slot.rd;
        w.lmis = mem_slot.is_load && mem_slot.mis;
        w.smis = mem_slot.is_store && mem_slot.mis;
        w.regw = !mem_slot.is_store && !mem_slot.mis;
        if (mem_slot.mis || mem_slot.is_store)
            w.data = 64'd0;
        else if (mem_slot.is_load)
            w.data = load_model(mem_slot.value, mem_slot.f3);
        else
            w.data = mem_slot.value;
        if (mem_slot.is_store && !mem_slot.mis)
            store_model(mem_slot.value, mem_slot.f3, mem_slot.sdata);
        exp_q.push_back(w);
    end
    if (flush)
        mem_slot.valid = 1'b0;
    else if (!stall)
        mem_slot = execute_model();
endtask

//--- dv/tb_riscv_em_top.sv
`timescale 1ns/1ps

module tb_riscv_em_top
    import riscv_core_pkg::*;
();

    localparam int DMEM_DEPTH = 64;

    logic        clk;
    logic        rst;
    logic        valid;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic [63:0] rs1data;
    logic [63:0] rs2data;
    logic [63:0] imm;
    logic [4:0]  rdaddr;
    logic        stall;
    logic        flush;
    logic        wb_valid;
    logic        wb_regw;
    logic [4:0]  wb_rdaddr;
    logic [63:0] wb_data;
    logic        wb_lmis;
    logic        wb_smis;
    int          errors;
    int          checks;
    int          wait_cnt;
    string       phase;

    `include "tb_riscv_em_model.svh"

    wb_t         got;

    riscv_em_top #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dut (
        .i_riscv_em_clk                 (clk),
        .i_riscv_em_rst                 (rst),
        .i_riscv_em_valid               (valid),
        .i_riscv_em_opcode              (opcode),
        .i_riscv_em_funct3              (funct3),
        .i_riscv_em_funct7b5            (funct7b5),
        .i_riscv_em_rs1data             (rs1data),
        .i_riscv_em_rs2data             (rs2data),
        .i_riscv_em_imm                 (imm),
        .i_riscv_em_rdaddr              (rdaddr),
        .i_riscv_em_stall               (stall),
        .i_riscv_em_flush               (flush),
        .o_riscv_em_wb_valid            (wb_valid),
        .o_riscv_em_wb_regw             (wb_regw),
        .o_riscv_em_wb_rdaddr           (wb_rdaddr),
        .o_riscv_em_wb_data             (wb_data),
        .o_riscv_em_wb_load_misaligned  (wb_lmis),
        .o_riscv_em_wb_store_misaligned (wb_smis)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_slot.valid = 1'b0;
            exp_q.delete();
        end
        else
            model_edge();
    end

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("FAILED %s/%s expected %h actual %h", phase, name, exp, act);
            errors++;
        end
    endtask

    // ==============================
    // Writeback monitor
    // ==============================

    always @(negedge clk)
    begin
        if (!rst && wb_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("Writeback appeared in %s when none was expected", phase);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                got = exp_q.pop_front();
                compare_field("wb_regw", 64'(got.regw), 64'(wb_regw));
                compare_field("wb_rdaddr", 64'(got.rd), 64'(wb_rdaddr));
                compare_field("wb_data", got.data, wb_data);
                compare_field("wb_load_misaligned", 64'(got.lmis), 64'(wb_lmis));
                compare_field("wb_store_misaligned", 64'(got.smis), 64'(wb_smis));
            end
        end
        else if (!rst)
        begin
            assert (exp_q.size() == 0)
            else
            begin
                $display("Expected writeback missing in %s", phase);
                errors++;
                exp_q.delete();
            end
        end
    end

    function automatic logic [63:0] fill_word(input logic [63:0] addr);
        return {addr[31:0] ^ 32'h5a5a_c3c3, ~addr[31:0]} ^ {32'd0, addr[63:32]};
    endfunction

    task automatic issue(input logic v, input opcode_e opc, input logic [2:0] f3,
                         input logic f7b5, input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] im, input logic [4:0] rd);
        valid    = v;
        opcode   = opc;
        funct3   = f3;
        funct7b5 = f7b5;
        rs1data  = a;
        rs2data  = b;
        imm      = im;
        rdaddr   = rd;
        @(posedge clk);
        #1;
    endtask

    task automatic random_instr(input logic ctrl);
        logic [2:0]  f3;
        logic [63:0] base;
        logic [63:0] off;
        int          kind;
        kind  = int'($urandom % 10);
        stall = ctrl && (($urandom % 8) == 0);
        flush = ctrl && (($urandom % 16) == 0);
        off   = 64'($urandom % 64);
        base  = 64'($urandom % 512);
        if (kind < 4)
        begin
            f3 = 3'($urandom % 7);
            if (f3 >= 3'd3)
                f3 = f3 + 3'd1;
            issue(1'b1, ($urandom % 2) ? OPC_OP : OPC_OP_IMM, f3, 1'($urandom),
                  {$urandom, $urandom}, {$urandom, $urandom}, {$urandom, $urandom},
                  5'($urandom));
        end
        else if (kind < 9)
        begin
            f3 = (kind < 7) ? 3'($urandom % 7) : 3'($urandom % 4);
            // Most accesses are aligned and the rest keep their random low bits
            if (($urandom % 4) != 0)
                base = base & ~((64'd1 << f3[1:0]) - 64'd1);
            issue(1'b1, (kind < 7) ? OPC_LOAD : OPC_STORE, f3, 1'b0, base - off,
                  {$urandom, $urandom}, off, 5'($urandom));
        end
        else
            issue(1'b0, OPC_OP, 3'd0, 1'b0, 64'd0, 64'd0, 64'd0, 5'd0);
    endtask

    initial
    begin
        void'($urandom(85276));
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        errors = 0;
        checks = 0;
        phase = "reset";
        mem_slot.valid = 1'b0;
        for (int i = 0; i < DMEM_DEPTH; i++)
            shadow_mem[i] = 64'd0;
        valid = 1'b0;
        opcode = OPC_OP;
        funct3 = 3'd0;
        funct7b5 = 1'b0;
        rs1data = 64'd0;
        rs2data = 64'd0;
        imm = 64'd0;
        rdaddr = 5'd0;
        repeat (5) @(posedge clk);
        #1;
        assert (!wb_valid && !wb_regw && !wb_lmis && !wb_smis)
        else
        begin
            $display("Writeback outputs are not low during reset");
            errors++;
        end
        rst = 1'b0;
        phase = "preload";
        for (int i = 0; i < DMEM_DEPTH; i++)
            issue(1'b1, OPC_STORE, 3'b011, 1'b0, 64'(i * 8), fill_word(64'(i * 8)),
                  64'd0, 5'd0);
        phase = "in_order";
        repeat (400) random_instr(1'b0);
        phase = "stall_flush";
        repeat (3000) random_instr(1'b1);
        phase = "drain";
        stall = 1'b0;
        flush = 1'b0;
        issue(1'b0, OPC_OP, 3'd0, 1'b0, 64'd0, 64'd0, 64'd0, 5'd0);
        wait_cnt = 0;
        while ((mem_slot.valid || exp_q.size() != 0) && wait_cnt < 20)
        begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        assert (wait_cnt < 20)
        else
        begin
            $display("Timed out waiting for the pipeline to drain");
            errors++;
        end
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- hdl/riscv_em_top.sv
`timescale 1ns/1ps

module riscv_em_top
    import riscv_core_pkg::*;
#(
    parameter int DMEM_DEPTH = 64
)
(
    input  logic       i_riscv_em_clk,
    input  logic       i_riscv_em_rst,
    input  logic       i_riscv_em_valid,
    input  opcode_e    i_riscv_em_opcode,
    input  logic [2:0] i_riscv_em_funct3,
    input  logic       i_riscv_em_funct7b5,
    input  xlen_t      i_riscv_em_rs1data,
    input  xlen_t      i_riscv_em_rs2data,
    input  xlen_t      i_riscv_em_imm,
    input  reg_addr_t  i_riscv_em_rdaddr,
    input  logic       i_riscv_em_stall,
    input  logic       i_riscv_em_flush,
    output logic       o_riscv_em_wb_valid,
    output logic       o_riscv_em_wb_regw,
    output reg_addr_t  o_riscv_em_wb_rdaddr,
    output xlen_t      o_riscv_em_wb_data,
    output logic       o_riscv_em_wb_load_misaligned,
    output logic       o_riscv_em_wb_store_misaligned
);

    // Execute side and memory side of the pipeline register
    riscv_em_if em_e ();
    riscv_em_if em_m ();

    riscv_execute u_execute (
        .i_riscv_em_valid    (i_riscv_em_valid),
        .i_riscv_em_opcode   (i_riscv_em_opcode),
        .i_riscv_em_funct3   (i_riscv_em_funct3),
        .i_riscv_em_funct7b5 (i_riscv_em_funct7b5),
        .i_riscv_em_rs1data  (i_riscv_em_rs1data),
        .i_riscv_em_rs2data  (i_riscv_em_rs2data),
        .i_riscv_em_imm      (i_riscv_em_imm),
        .i_riscv_em_rdaddr   (i_riscv_em_rdaddr),
        .em_e                (em_e.producer)
    );

    riscv_ppreg_em u_ppreg_em (
        .i_riscv_em_clk   (i_riscv_em_clk),
        .i_riscv_em_rst   (i_riscv_em_rst),
        .i_riscv_em_stall (i_riscv_em_stall),
        .i_riscv_em_flush (i_riscv_em_flush),
        .em_e             (em_e.consumer),
        .em_m             (em_m.producer)
    );

    riscv_memstage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_memstage (
        .i_riscv_em_clk                 (i_riscv_em_clk),
        .i_riscv_em_rst                 (i_riscv_em_rst),
        .i_riscv_em_stall               (i_riscv_em_stall),
        .em_m                           (em_m.consumer),
        .o_riscv_em_wb_valid            (o_riscv_em_wb_valid),
        .o_riscv_em_wb_regw             (o_riscv_em_wb_regw),
        .o_riscv_em_wb_rdaddr           (o_riscv_em_wb_rdaddr),
        .o_riscv_em_wb_data             (o_riscv_em_wb_data),
        .o_riscv_em_wb_load_misaligned  (o_riscv_em_wb_load_misaligned),
        .o_riscv_em_wb_store_misaligned (o_riscv_em_wb_store_misaligned)
    );

endmodule

//--- hdl/riscv_memstage.sv
`timescale 1ns/1ps

module riscv_memstage
    import riscv_core_pkg::*;
    import riscv_mem_pkg::*;
#(
    parameter int DMEM_DEPTH = 64
)
(
    input  logic         i_riscv_em_clk,
    input  logic         i_riscv_em_rst,
    input  logic         i_riscv_em_stall,
    riscv_em_if.consumer em_m,
    output logic         o_riscv_em_wb_valid,
    output logic         o_riscv_em_wb_regw,
    output reg_addr_t    o_riscv_em_wb_rdaddr,
    output xlen_t        o_riscv_em_wb_data,
    output logic         o_riscv_em_wb_load_misaligned,
    output logic         o_riscv_em_wb_store_misaligned
);

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    xlen_t            dmem [DMEM_DEPTH];
    dmem_addr_t       addr;
    logic [IDX_W-1:0] idx;
    logic [2:0]       offset;
    byte_mask_t       lane_base;
    byte_mask_t       lane_mask;
    xlen_t            wdata;
    xlen_t            rword;
    xlen_t            ldata;
    xlen_t            wb_data_d;
    logic             misaligned;
    logic             mem_we;
    logic             wb_en;

    assign addr       = em_m.result;
    // Depth is a power of two, so dropping the upper bits wraps the index
    assign idx        = addr[3 +: IDX_W];
    assign offset     = addr[2:0];
    assign misaligned = em_m.load_misaligned | em_m.store_misaligned;

    // ==============================
    // Store path
    // ==============================

    always_comb
    begin
        case (em_m.memext[1:0])
            2'b00:   lane_base = 8'h01;
            2'b01:   lane_base = 8'h03;
            2'b10:   lane_base = 8'h0f;
            default: lane_base = 8'hff;
        endcase
    end

    assign lane_mask = lane_base << offset;
    assign wdata     = em_m.storedata << {offset, 3'b000};
    assign mem_we    = em_m.valid & em_m.store & ~misaligned & ~i_riscv_em_stall;

    always_ff @(posedge i_riscv_em_clk)
    begin : dmem_write_proc
        for (int i = 0; i < 8; i++)
        begin
            if (mem_we && lane_mask[i])
            begin
                dmem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // ==============================
    // Load path and writeback
    // ==============================

    assign rword = dmem[idx] >> {offset, 3'b000};

    always_comb
    begin
        case (em_m.memext)
            MEM_B:   ldata = {{56{rword[7]}}, rword[7:0]};
            MEM_H:   ldata = {{48{rword[15]}}, rword[15:0]};
            MEM_W:   ldata = {{32{rword[31]}}, rword[31:0]};
            MEM_BU:  ldata = {56'd0, rword[7:0]};
            MEM_HU:  ldata = {48'd0, rword[15:0]};
            MEM_WU:  ldata = {32'd0, rword[31:0]};
            default: ldata = rword;
        endcase
    end

    // A misaligned access reports its flag with zero data
    always_comb
    begin
        if (misaligned)
            wb_data_d = '0;
        else if (em_m.resultsrc == RES_ALU)
            wb_data_d = em_m.result;
        else if (em_m.resultsrc == RES_MEM)
            wb_data_d = ldata;
        else
            wb_data_d = '0;
    end

    // A stalled edge writes a bubble into the writeback register
    assign wb_en = em_m.valid & ~i_riscv_em_stall;

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : wb_ctrl_proc
        if (i_riscv_em_rst)
        begin
            o_riscv_em_wb_valid            <= 1'b0;
            o_riscv_em_wb_regw             <= 1'b0;
            o_riscv_em_wb_load_misaligned  <= 1'b0;
            o_riscv_em_wb_store_misaligned <= 1'b0;
        end
        else
        begin
            o_riscv_em_wb_valid            <= wb_en;
            o_riscv_em_wb_regw             <= wb_en & em_m.regw & ~misaligned;
            o_riscv_em_wb_load_misaligned  <= wb_en & em_m.load_misaligned;
            o_riscv_em_wb_store_misaligned <= wb_en & em_m.store_misaligned;
        end
    end

    always_ff @(posedge i_riscv_em_clk)
    begin : wb_data_proc
        o_riscv_em_wb_rdaddr <= em_m.rdaddr;
        o_riscv_em_wb_data   <= wb_data_d;
    end

    // A misaligned access leaves its RAM word untouched
    a_no_misaligned_write : assert property (
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        misaligned |=> (dmem[$past(idx)] == $past(dmem[idx]))
    );

endmodule

//--- hdl/riscv_ppreg_em.sv
`timescale 1ns/1ps

module riscv_ppreg_em
    import riscv_core_pkg::*;
    import riscv_mem_pkg::*;
(
    input  logic         i_riscv_em_clk,
    input  logic         i_riscv_em_rst,
    input  logic         i_riscv_em_stall,
    input  logic         i_riscv_em_flush,
    riscv_em_if.consumer em_e,
    riscv_em_if.producer em_m
);

    // Flush wins over stall, and either way the input record of that cycle is dropped
    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : em_preg_proc
        if (i_riscv_em_rst)
        begin
            em_m.valid            <= 1'b0;
            em_m.rdaddr           <= '0;
            em_m.regw             <= 1'b0;
            em_m.resultsrc        <= RES_NONE;
            em_m.memext           <= MEM_B;
            em_m.store            <= 1'b0;
            em_m.result           <= '0;
            em_m.storedata        <= '0;
            em_m.load_misaligned  <= 1'b0;
            em_m.store_misaligned <= 1'b0;
        end
        else if (i_riscv_em_flush)
        begin
            em_m.valid            <= 1'b0;
            em_m.rdaddr           <= '0;
            em_m.regw             <= 1'b0;
            em_m.resultsrc        <= RES_NONE;
            em_m.memext           <= MEM_B;
            em_m.store            <= 1'b0;
            em_m.result           <= '0;
            em_m.storedata        <= '0;
            em_m.load_misaligned  <= 1'b0;
            em_m.store_misaligned <= 1'b0;
        end
        else if (!i_riscv_em_stall)
        begin
            em_m.valid            <= em_e.valid;
            em_m.rdaddr           <= em_e.rdaddr;
            em_m.regw             <= em_e.regw;
            em_m.resultsrc        <= em_e.resultsrc;
            em_m.memext           <= em_e.memext;
            em_m.store            <= em_e.store;
            em_m.result           <= em_e.result;
            em_m.storedata        <= em_e.storedata;
            em_m.load_misaligned  <= em_e.load_misaligned;
            em_m.store_misaligned <= em_e.store_misaligned;
        end
    end

    // A flushed slot must reach the memory stage as a bubble
    a_flush_bubble : assert property (
        @(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_riscv_em_flush |=> !em_m.valid
    );

endmodule

//--- hdl/riscv_execute.sv
`timescale 1ns/1ps

module riscv_execute
    import riscv_core_pkg::*;
    import riscv_mem_pkg::*;
(
    input  logic         i_riscv_em_valid,
    input  opcode_e      i_riscv_em_opcode,
    input  logic [2:0]   i_riscv_em_funct3,
    input  logic         i_riscv_em_funct7b5,
    input  xlen_t        i_riscv_em_rs1data,
    input  xlen_t        i_riscv_em_rs2data,
    input  xlen_t        i_riscv_em_imm,
    input  reg_addr_t    i_riscv_em_rdaddr,
    riscv_em_if.producer em_e
);

    logic       is_op;
    logic       is_op_imm;
    logic       is_load;
    logic       is_store;
    logic       known;
    alu_op_e    alu_op;
    xlen_t      op_b;
    xlen_t      alu_res;
    logic [2:0] size_mask;
    logic       addr_misaligned;

    assign is_op     = (i_riscv_em_opcode == OPC_OP);
    assign is_op_imm = (i_riscv_em_opcode == OPC_OP_IMM);
    assign is_load   = (i_riscv_em_opcode == OPC_LOAD);
    assign is_store  = (i_riscv_em_opcode == OPC_STORE);
    assign known     = is_op | is_op_imm | is_load | is_store;

    // Loads and stores fall through to ADD for the address
    always_comb
    begin
        alu_op = ALU_ADD;
        if (is_op || is_op_imm)
        begin
            case (i_riscv_em_funct3)
                3'b000:  alu_op = (is_op && i_riscv_em_funct7b5) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign op_b = is_op ? i_riscv_em_rs2data : i_riscv_em_imm;

    always_comb
    begin
        case (alu_op)
            ALU_ADD: alu_res = i_riscv_em_rs1data + op_b;
            ALU_SUB: alu_res = i_riscv_em_rs1data - op_b;
            ALU_AND: alu_res = i_riscv_em_rs1data & op_b;
            ALU_OR:  alu_res = i_riscv_em_rs1data | op_b;
            ALU_XOR: alu_res = i_riscv_em_rs1data ^ op_b;
            ALU_SLT: alu_res = {63'd0, $signed(i_riscv_em_rs1data) < $signed(op_b)};
            ALU_SLL: alu_res = i_riscv_em_rs1data << op_b[5:0];
            ALU_SRL: alu_res = i_riscv_em_rs1data >> op_b[5:0];
        endcase
    end

    // Low address bits that must be zero for byte, half, word and double
    assign size_mask = {i_riscv_em_funct3[1:0] == 2'b11,
                        i_riscv_em_funct3[1],
                        i_riscv_em_funct3[1:0] != 2'b00};
    assign addr_misaligned = |(alu_res[2:0] & size_mask);

    assign em_e.valid            = i_riscv_em_valid & known;
    assign em_e.rdaddr           = i_riscv_em_rdaddr;
    assign em_e.regw             = i_riscv_em_valid & (is_op | is_op_imm | is_load);
    assign em_e.resultsrc        = is_load ? RES_MEM : ((is_op | is_op_imm) ? RES_ALU : RES_NONE);
    assign em_e.memext           = memext_e'(i_riscv_em_funct3);
    assign em_e.store            = i_riscv_em_valid & is_store;
    assign em_e.result           = alu_res;
    assign em_e.storedata        = i_riscv_em_rs2data;
    assign em_e.load_misaligned  = i_riscv_em_valid & is_load & addr_misaligned;
    assign em_e.store_misaligned = i_riscv_em_valid & is_store & addr_misaligned;

endmodule

//--- hdl/riscv_em_if.sv
`timescale 1ns/1ps

interface riscv_em_if
    import riscv_core_pkg::*;
    import riscv_mem_pkg::*;
();

    logic       valid;
    reg_addr_t  rdaddr;
    logic       regw;
    resultsrc_e resultsrc;
    memext_e    memext;
    logic       store;
    // ALU result, or the effective address for loads and stores
    xlen_t      result;
    xlen_t      storedata;
    logic       load_misaligned;
    logic       store_misaligned;

    modport producer (
        output valid, rdaddr, regw, resultsrc, memext, store,
        output result, storedata, load_misaligned, store_misaligned
    );

    modport consumer (
        input valid, rdaddr, regw, resultsrc, memext, store,
        input result, storedata, load_misaligned, store_misaligned
    );

endinterface

//--- hdl/riscv_mem_pkg.sv
package riscv_mem_pkg;

    localparam int DMEM_ADDR_W = 64;

    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

    // One bit per byte lane of a doubleword
    typedef logic [7:0] byte_mask_t;

    // ==============================
    // Access size and extension
    // ==============================

    // Values follow the load/store funct3 field and bit 2 marks zero extension
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } memext_e;

endpackage

//--- hdl/riscv_core_pkg.sv
package riscv_core_pkg;

    // ==============================
    // Datapath widths
    // ==============================

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ==============================
    // Instruction encodings
    // ==============================

    // Only the major opcodes handled by the execute/memory slice
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_e;

    // Selects what the writeback record carries as data
    typedef enum logic [1:0] {
        RES_ALU  = 2'd0,
        RES_MEM  = 2'd1,
        RES_NONE = 2'd2
    } resultsrc_e;

endpackage
